// ==== axi_line_pkg.sv ====
`default_nettype none

package axi_line_pkg;

  localparam int LINE_W  = 512;
  localparam int BEAT_W  = 64;
  localparam int STRB_W  = BEAT_W / 8;
  localparam int BEATS_W = 3;  // Holds beats minus one.
  localparam int ADDR_W  = 32;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Coded as the AXI size field.
  typedef enum logic [2:0] {
    SIZE_B = 3'd0,
    SIZE_H = 3'd1,
    SIZE_W = 3'd2,
    SIZE_D = 3'd3
  } size_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

// ==== line_req_queue.sv ====
`default_nettype none

module line_req_queue import axi_line_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  op_e                  req_op_i,
  input  logic [ADDR_W-1:0]    req_addr_i,
  input  size_e                req_size_i,
  input  logic [BEATS_W-1:0]   req_blks_i,
  input  logic [LINE_W-1:0]    req_wdata_i,
  output logic                 q_valid_o,
  input  logic                 q_ready_i,
  output op_e                  q_op_o,
  output logic [ADDR_W-1:0]    q_addr_o,
  output size_e                q_size_o,
  output logic [BEATS_W-1:0]   q_blks_o,
  output logic [LINE_W-1:0]    q_wdata_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  op_e                op_mem   [QUEUE_DEPTH];
  logic [ADDR_W-1:0]  addr_mem [QUEUE_DEPTH];
  size_e              size_mem [QUEUE_DEPTH];
  logic [BEATS_W-1:0] blks_mem [QUEUE_DEPTH];
  logic [LINE_W-1:0]  data_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W:0]     count_q;
  logic               push;
  logic               pop;

  assign req_ready_o = (count_q != (PTR_W + 1)'(QUEUE_DEPTH));
  assign q_valid_o   = (count_q != '0);
  assign push        = req_valid_i && req_ready_o;
  assign pop         = q_valid_o && q_ready_i;

  // The head entry is presented straight from its storage register.
  assign q_op_o    = op_mem[rd_ptr_q];
  assign q_addr_o  = addr_mem[rd_ptr_q];
  assign q_size_o  = size_mem[rd_ptr_q];
  assign q_blks_o  = blks_mem[rd_ptr_q];
  assign q_wdata_o = data_mem[rd_ptr_q];

  always_ff @(posedge clock) begin
    if (push) begin
      op_mem[wr_ptr_q]   <= req_op_i;
      addr_mem[wr_ptr_q] <= req_addr_i;
      size_mem[wr_ptr_q] <= req_size_i;
      blks_mem[wr_ptr_q] <= req_blks_i;
      data_mem[wr_ptr_q] <= req_wdata_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== axi_burst_engine.sv ====
`default_nettype none

module axi_burst_engine import axi_line_pkg::*; #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic                 clock,
  input  logic                 reset,

  input  logic                 q_valid_i,
  output logic                 q_ready_o,
  input  op_e                  q_op_i,
  input  logic [ADDR_W-1:0]    q_addr_i,
  input  size_e                q_size_i,
  input  logic [BEATS_W-1:0]   q_blks_i,
  input  logic [LINE_W-1:0]    q_wdata_i,

  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output op_e                  resp_op_o,
  output resp_e                resp_status_o,
  output logic [LINE_W-1:0]    resp_rdata_o,

  input  logic                 axi_aw_ready_i,
  output logic                 axi_aw_valid_o,
  output logic [ADDR_W-1:0]    axi_aw_addr_o,
  output logic [3:0]           axi_aw_id_o,
  output logic [7:0]           axi_aw_len_o,
  output size_e                axi_aw_size_o,
  output logic [1:0]           axi_aw_burst_o,

  input  logic                 axi_w_ready_i,
  output logic                 axi_w_valid_o,
  output logic [BEAT_W-1:0]    axi_w_data_o,
  output logic [STRB_W-1:0]    axi_w_strb_o,
  output logic                 axi_w_last_o,

  output logic                 axi_b_ready_o,
  input  logic                 axi_b_valid_i,
  input  resp_e                axi_b_resp_i,

  input  logic                 axi_ar_ready_i,
  output logic                 axi_ar_valid_o,
  output logic [ADDR_W-1:0]    axi_ar_addr_o,
  output logic [3:0]           axi_ar_id_o,
  output logic [7:0]           axi_ar_len_o,
  output size_e                axi_ar_size_o,
  output logic [1:0]           axi_ar_burst_o,

  output logic                 axi_r_ready_o,
  input  logic                 axi_r_valid_i,
  input  logic [BEAT_W-1:0]    axi_r_data_i,
  input  resp_e                axi_r_resp_i,
  input  logic                 axi_r_last_i
);

  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef enum logic [2:0] {
    IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP,
    RD_ADDR,
    RD_DATA,
    DONE
  } state_e;

  state_e             state_q;
  op_e                op_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [ADDR_W-1:0]  beat_addr_q;  // Address of the beat now on W.
  size_e              size_q;
  logic [BEATS_W-1:0] blks_q;
  logic [BEATS_W-1:0] beat_q;
  logic [LINE_W-1:0]  wline_q;
  logic [LINE_W-1:0]  rline_q;
  resp_e              status_q;
  logic               last_beat;
  logic               accept;
  logic               w_fire;
  logic               r_fire;
  logic               b_fire;

  // Byte lanes that a narrow beat may touch, taken from the size and address.
  function automatic logic [STRB_W-1:0] beat_strb(size_e size, logic [2:0] offset);
    logic [STRB_W-1:0] strb;
    case (size)
      SIZE_B:  strb = 8'h01 << offset;
      SIZE_H:  strb = 8'h03 << {offset[2:1], 1'b0};
      SIZE_W:  strb = 8'h0f << {offset[2], 2'b00};
      default: strb = 8'hff;
    endcase
    return strb;
  endfunction

  assign accept    = (state_q == IDLE) && q_valid_i;
  assign w_fire    = axi_w_valid_o && axi_w_ready_i;
  assign r_fire    = axi_r_valid_i && axi_r_ready_o;
  assign b_fire    = axi_b_valid_i && axi_b_ready_o;
  assign last_beat = (beat_q == blks_q);

  assign q_ready_o = (state_q == IDLE);  // DONE holds the completion, so idle means free.

  assign axi_aw_valid_o = (state_q == WR_ADDR);
  assign axi_aw_addr_o  = addr_q;
  assign axi_aw_id_o    = AXI_ID;
  assign axi_aw_len_o   = {{(8 - BEATS_W){1'b0}}, blks_q};
  assign axi_aw_size_o  = size_q;
  assign axi_aw_burst_o = BURST_INCR;

  assign axi_w_valid_o = (state_q == WR_DATA);
  assign axi_w_data_o  = wline_q[BEAT_W-1:0];  // The line is shifted down once per beat.
  assign axi_w_strb_o  = beat_strb(size_q, beat_addr_q[2:0]);
  assign axi_w_last_o  = (state_q == WR_DATA) && last_beat;

  assign axi_b_ready_o = (state_q == WR_RESP);

  assign axi_ar_valid_o = (state_q == RD_ADDR);
  assign axi_ar_addr_o  = addr_q;
  assign axi_ar_id_o    = AXI_ID;
  assign axi_ar_len_o   = {{(8 - BEATS_W){1'b0}}, blks_q};
  assign axi_ar_size_o  = size_q;
  assign axi_ar_burst_o = BURST_INCR;

  assign axi_r_ready_o = (state_q == RD_DATA);

  assign resp_valid_o  = (state_q == DONE);
  assign resp_op_o     = op_q;
  assign resp_status_o = status_q;
  assign resp_rdata_o  = rline_q;  // Stays zero for a write.

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (q_valid_i) begin
            state_q <= (q_op_i == OP_WRITE) ? WR_ADDR : RD_ADDR;
            beat_q  <= '0;
          end
        end
        WR_ADDR: begin
          if (axi_aw_ready_i) begin
            state_q <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (axi_w_ready_i) begin
            if (last_beat) begin
              state_q <= WR_RESP;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        WR_RESP: begin
          if (axi_b_valid_i) begin
            state_q <= DONE;
          end
        end
        RD_ADDR: begin
          if (axi_ar_ready_i) begin
            state_q <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (axi_r_valid_i) begin
            if (axi_r_last_i) begin
              state_q <= DONE;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        DONE: begin
          if (resp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q        <= q_op_i;
      addr_q      <= q_addr_i;
      beat_addr_q <= q_addr_i;
      size_q      <= q_size_i;
      blks_q      <= q_blks_i;
      wline_q     <= q_wdata_i;
      rline_q     <= '0;
      status_q    <= RESP_OKAY;
    end
    if (w_fire) begin
      wline_q     <= wline_q >> BEAT_W;
      beat_addr_q <= beat_addr_q + (ADDR_W'(1) << size_q);
    end
    // Only the first response that is not OKAY is kept.
    if (b_fire && status_q == RESP_OKAY) begin
      status_q <= axi_b_resp_i;
    end
    if (r_fire) begin
      rline_q[beat_q*BEAT_W +: BEAT_W] <= axi_r_data_i;
      if (status_q == RESP_OKAY) begin
        status_q <= axi_r_resp_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== axi_line_master.sv ====
`default_nettype none

module axi_line_master import axi_line_pkg::*; #(
  parameter int         QUEUE_DEPTH = 4,
  parameter logic [3:0] AXI_ID      = 4'd0
) (
  input  logic                 clock,
  input  logic                 reset,

  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  op_e                  req_op_i,
  input  logic [ADDR_W-1:0]    req_addr_i,
  input  size_e                req_size_i,
  input  logic [BEATS_W-1:0]   req_blks_i,
  input  logic [LINE_W-1:0]    req_wdata_i,

  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output op_e                  resp_op_o,
  output resp_e                resp_status_o,
  output logic [LINE_W-1:0]    resp_rdata_o,

  input  logic                 axi_aw_ready_i,
  output logic                 axi_aw_valid_o,
  output logic [ADDR_W-1:0]    axi_aw_addr_o,
  output logic [3:0]           axi_aw_id_o,
  output logic [7:0]           axi_aw_len_o,
  output size_e                axi_aw_size_o,
  output logic [1:0]           axi_aw_burst_o,

  input  logic                 axi_w_ready_i,
  output logic                 axi_w_valid_o,
  output logic [BEAT_W-1:0]    axi_w_data_o,
  output logic [STRB_W-1:0]    axi_w_strb_o,
  output logic                 axi_w_last_o,

  output logic                 axi_b_ready_o,
  input  logic                 axi_b_valid_i,
  input  resp_e                axi_b_resp_i,

  input  logic                 axi_ar_ready_i,
  output logic                 axi_ar_valid_o,
  output logic [ADDR_W-1:0]    axi_ar_addr_o,
  output logic [3:0]           axi_ar_id_o,
  output logic [7:0]           axi_ar_len_o,
  output size_e                axi_ar_size_o,
  output logic [1:0]           axi_ar_burst_o,

  output logic                 axi_r_ready_o,
  input  logic                 axi_r_valid_i,
  input  logic [BEAT_W-1:0]    axi_r_data_i,
  input  resp_e                axi_r_resp_i,
  input  logic                 axi_r_last_i
);

  // Head of the request queue as seen by the burst engine.
  logic               q_valid;
  logic               q_ready;
  op_e                q_op;
  logic [ADDR_W-1:0]  q_addr;
  size_e              q_size;
  logic [BEATS_W-1:0] q_blks;
  logic [LINE_W-1:0]  q_wdata;

  line_req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .q_valid_o   (q_valid),
    .q_ready_i   (q_ready),
    .q_op_o      (q_op),
    .q_addr_o    (q_addr),
    .q_size_o    (q_size),
    .q_blks_o    (q_blks),
    .q_wdata_o   (q_wdata),
    .*
  );

  axi_burst_engine #(
    .AXI_ID      (AXI_ID)
  ) u_engine (
    .q_valid_i   (q_valid),
    .q_ready_o   (q_ready),
    .q_op_i      (q_op),
    .q_addr_i    (q_addr),
    .q_size_i    (q_size),
    .q_blks_i    (q_blks),
    .q_wdata_i   (q_wdata),
    .*
  );

endmodule

`default_nettype wire

// ==== tb_axi_slave.sv ====
`default_nettype none

module tb_axi_slave import axi_line_pkg::*; #(
  parameter logic [3:0]  EXPECT_ID = 4'd3,
  parameter logic [31:0] ERR_BASE  = 32'h800
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [3:0]        aw_id_i,
  input  size_e             aw_size_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  logic [BEAT_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output resp_e             b_resp_o,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [3:0]        ar_id_i,
  input  logic [7:0]        ar_len_i,
  input  size_e             ar_size_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [BEAT_W-1:0] r_data_o,
  output resp_e             r_resp_o,
  output logic              r_last_o,
  output logic              id_error_o
);

  logic [7:0]        mem [4096];
  logic              aw_ready_q;
  logic              wr_active_q;
  logic [ADDR_W-1:0] wr_addr_q;
  size_e             wr_size_q;
  resp_e             wr_resp_q;
  logic [2:0]        w_cnt_q;
  logic              w_hold_q;
  logic              b_valid_q;
  logic              ar_ready_q;
  logic              rd_active_q;
  logic [ADDR_W-1:0] rd_addr_q;
  size_e             rd_size_q;
  logic [7:0]        rd_len_q;
  logic [7:0]        rd_cnt_q;
  resp_e             rd_resp_q;
  logic              r_hold_q;
  logic              id_error_q;

  // Every byte gets a value that depends on all twelve address bits.
  function automatic logic [7:0] fill_byte(logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  assign aw_ready_o = aw_ready_q;
  assign w_ready_o  = wr_active_q && !w_hold_q;
  assign b_valid_o  = b_valid_q;
  assign b_resp_o   = wr_resp_q;
  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = rd_active_q && !r_hold_q;
  assign r_resp_o   = rd_resp_q;
  assign r_last_o   = (rd_cnt_q == rd_len_q);
  assign id_error_o = id_error_q;

  always_comb begin
    for (int j = 0; j < STRB_W; j++) begin
      r_data_o[8*j +: 8] = mem[{rd_addr_q[11:3], 3'(j)}];  // Whole aligned beat.
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_ready_q  <= 1'b0;
      wr_active_q <= 1'b0;
      w_cnt_q     <= '0;
      w_hold_q    <= 1'b0;
      b_valid_q   <= 1'b0;
      wr_resp_q   <= RESP_OKAY;
      for (int i = 0; i < 4096; i++) begin
        mem[i] <= fill_byte(12'(i));
      end
    end else begin
      aw_ready_q <= aw_valid_i && !aw_ready_q && !wr_active_q && !b_valid_q;
      if (aw_valid_i && aw_ready_q) begin
        wr_active_q <= 1'b1;
        wr_addr_q   <= aw_addr_i;
        wr_size_q   <= aw_size_i;
        w_cnt_q     <= '0;
        if (aw_addr_i >= ERR_BASE) begin
          wr_resp_q <= RESP_SLVERR;
        end else begin
          wr_resp_q <= RESP_OKAY;
        end
      end
      if (w_valid_i && w_ready_o) begin
        for (int j = 0; j < STRB_W; j++) begin
          if (w_strb_i[j] && wr_resp_q == RESP_OKAY) begin
            mem[{wr_addr_q[11:3], 3'(j)}] <= w_data_i[8*j +: 8];
          end
        end
        wr_addr_q <= wr_addr_q + (ADDR_W'(1) << wr_size_q);
        w_cnt_q   <= w_cnt_q + 1'b1;
        w_hold_q  <= w_cnt_q[0];  // Ready drops after every second beat.
        if (w_last_i) begin
          wr_active_q <= 1'b0;
          b_valid_q   <= 1'b1;
        end
      end else begin
        w_hold_q <= 1'b0;
      end
      if (b_valid_q && b_ready_i) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_ready_q  <= 1'b0;
      rd_active_q <= 1'b0;
      rd_cnt_q    <= '0;
      r_hold_q    <= 1'b0;
      rd_resp_q   <= RESP_OKAY;
    end else begin
      ar_ready_q <= ar_valid_i && !ar_ready_q && !rd_active_q;
      if (ar_valid_i && ar_ready_q) begin
        rd_active_q <= 1'b1;
        rd_addr_q   <= ar_addr_i;
        rd_size_q   <= ar_size_i;
        rd_len_q    <= ar_len_i;
        rd_cnt_q    <= '0;
        if (ar_addr_i >= ERR_BASE) begin
          rd_resp_q <= RESP_SLVERR;
        end else begin
          rd_resp_q <= RESP_OKAY;
        end
      end
      if (r_valid_o && r_ready_i) begin
        rd_addr_q <= rd_addr_q + (ADDR_W'(1) << rd_size_q);
        rd_cnt_q  <= rd_cnt_q + 8'd1;
        r_hold_q  <= rd_cnt_q[0];
        if (r_last_o) begin
          rd_active_q <= 1'b0;
        end
      end else begin
        r_hold_q <= 1'b0;
      end
    end
  end

  // Rises on the first AXI id other than EXPECT_ID and stays high.
  always_ff @(posedge clock) begin
    if (reset) begin
      id_error_q <= 1'b0;
    end else if ((aw_valid_i && aw_ready_q && aw_id_i != EXPECT_ID) ||
                 (ar_valid_i && ar_ready_q && ar_id_i != EXPECT_ID)) begin
      id_error_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== tb_axi_line_master.sv ====
`default_nettype none

module tb_axi_line_master import axi_line_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;

  logic               clock;
  logic               reset;
  logic               req_valid_i;
  logic               req_ready_o;
  op_e                req_op_i;
  logic [ADDR_W-1:0]  req_addr_i;
  size_e              req_size_i;
  logic [BEATS_W-1:0] req_blks_i;
  logic [LINE_W-1:0]  req_wdata_i;
  logic               resp_valid_o;
  logic               resp_ready_i;
  op_e                resp_op_o;
  resp_e              resp_status_o;
  logic [LINE_W-1:0]  resp_rdata_o;
  logic               axi_aw_ready_i;
  logic               axi_aw_valid_o;
  logic [ADDR_W-1:0]  axi_aw_addr_o;
  logic [3:0]         axi_aw_id_o;
  logic [7:0]         axi_aw_len_o;
  size_e              axi_aw_size_o;
  logic [1:0]         axi_aw_burst_o;
  logic               axi_w_ready_i;
  logic               axi_w_valid_o;
  logic [BEAT_W-1:0]  axi_w_data_o;
  logic [STRB_W-1:0]  axi_w_strb_o;
  logic               axi_w_last_o;
  logic               axi_b_ready_o;
  logic               axi_b_valid_i;
  resp_e              axi_b_resp_i;
  logic               axi_ar_ready_i;
  logic               axi_ar_valid_o;
  logic [ADDR_W-1:0]  axi_ar_addr_o;
  logic [3:0]         axi_ar_id_o;
  logic [7:0]         axi_ar_len_o;
  size_e              axi_ar_size_o;
  logic [1:0]         axi_ar_burst_o;
  logic               axi_r_ready_o;
  logic               axi_r_valid_i;
  logic [BEAT_W-1:0]  axi_r_data_i;
  resp_e              axi_r_resp_i;
  logic               axi_r_last_i;
  logic               slave_id_error;

  logic [7:0]         ref_mem [4096];  // Mirror of the slave memory.
  op_e                exp_op_q [$];
  resp_e              exp_status_q [$];
  logic [LINE_W-1:0]  exp_line_q [$];
  logic [15:0]        lfsr_q = 16'd25682;
  logic [7:0]         aw_len_seen;
  int                 w_beats = 0;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;

  axi_line_master #(
    .QUEUE_DEPTH (4),
    .AXI_ID      (4'd3)
  ) dut (.*);

  tb_axi_slave slave (
    .clock      (clock),
    .reset      (reset),
    .aw_valid_i (axi_aw_valid_o),
    .aw_ready_o (axi_aw_ready_i),
    .aw_addr_i  (axi_aw_addr_o),
    .aw_id_i    (axi_aw_id_o),
    .aw_size_i  (axi_aw_size_o),
    .w_valid_i  (axi_w_valid_o),
    .w_ready_o  (axi_w_ready_i),
    .w_data_i   (axi_w_data_o),
    .w_strb_i   (axi_w_strb_o),
    .w_last_i   (axi_w_last_o),
    .b_valid_o  (axi_b_valid_i),
    .b_ready_i  (axi_b_ready_o),
    .b_resp_o   (axi_b_resp_i),
    .ar_valid_i (axi_ar_valid_o),
    .ar_ready_o (axi_ar_ready_i),
    .ar_addr_i  (axi_ar_addr_o),
    .ar_id_i    (axi_ar_id_o),
    .ar_len_i   (axi_ar_len_o),
    .ar_size_i  (axi_ar_size_o),
    .r_valid_o  (axi_r_valid_i),
    .r_ready_i  (axi_r_ready_o),
    .r_data_o   (axi_r_data_i),
    .r_resp_o   (axi_r_resp_i),
    .r_last_o   (axi_r_last_i),
    .id_error_o (slave_id_error)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  always @(posedge slave_id_error) begin
    errors++;
    $display("the slave saw an AXI id other than 3 on AW or AR");
  end

  // Every burst is INCR, and WLAST marks the beat that AWLEN names.
  always @(negedge clock) begin
    if (axi_aw_valid_o && axi_aw_ready_i) begin
      check_count("axi_aw_burst_o", int'(axi_aw_burst_o), 1);
      aw_len_seen = axi_aw_len_o;
      w_beats     = 0;
    end
    if (axi_ar_valid_o && axi_ar_ready_i) begin
      check_count("axi_ar_burst_o", int'(axi_ar_burst_o), 1);
    end
    if (axi_w_valid_o && axi_w_ready_i) begin
      check_bit("axi_w_last_o", axi_w_last_o, w_beats == int'(aw_len_seen));
      w_beats++;
    end
  end

  function automatic logic [7:0] fill_byte(logic [11:0] a);
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
  endfunction

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_line(output logic [LINE_W-1:0] line);
    for (int i = 0; i < LINE_W; i++) begin
      lfsr_q  = lfsr_next(lfsr_q);
      line[i] = lfsr_q[0];
    end
  endtask

  // A beat of 2**size bytes covers the aligned container that holds its address.
  function automatic bit lane_enabled(size_e size, logic [2:0] offset, int lane);
    int n;
    int base;
    n    = 1 << int'(size);
    base = int'(offset) - (int'(offset) % n);
    return (lane >= base) && (lane < base + n);
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input size_e size,
                             input logic [BEATS_W-1:0] blks, input logic [LINE_W-1:0] line);
    logic [ADDR_W-1:0] beat_addr;
    beat_addr = addr;
    if (addr >= 32'h800) begin
      return;  // The error range keeps its contents.
    end
    for (int k = 0; k <= int'(blks); k++) begin
      for (int j = 0; j < 8; j++) begin
        if (lane_enabled(size, beat_addr[2:0], j)) begin
          ref_mem[{beat_addr[11:3], 3'(j)}] = line[64*k + 8*j +: 8];
        end
      end
      beat_addr = beat_addr + (32'd1 << size);
    end
  endtask

  function automatic logic [LINE_W-1:0] model_read(logic [ADDR_W-1:0] addr, size_e size,
                                                   logic [BEATS_W-1:0] blks);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] beat_addr;
    line      = '0;
    beat_addr = addr;
    for (int k = 0; k <= int'(blks); k++) begin
      for (int j = 0; j < 8; j++) begin
        line[64*k + 8*j +: 8] = ref_mem[{beat_addr[11:3], 3'(j)}];
      end
      beat_addr = beat_addr + (32'd1 << size);
    end
    return line;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_op(input string name, input op_e got, input op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_status(input string name, input resp_e got, input resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_line(input string name, input logic [LINE_W-1:0] got,
                            input logic [LINE_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Records the expected completion, then hands the request over. Starts and ends on a falling edge.
  task automatic send_request(input op_e op, input logic [ADDR_W-1:0] addr, input size_e size,
                              input logic [BEATS_W-1:0] blks, input logic [LINE_W-1:0] line);
    exp_op_q.push_back(op);
    if (addr >= 32'h800) begin
      exp_status_q.push_back(RESP_SLVERR);
    end else begin
      exp_status_q.push_back(RESP_OKAY);
    end
    if (op == OP_WRITE) begin
      model_write(addr, size, blks, line);
      exp_line_q.push_back('0);
    end else begin
      exp_line_q.push_back(model_read(addr, size, blks));
    end
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_size_i  = size;
    req_blks_i  = blks;
    req_wdata_i = line;
    while (!req_ready_o) @(negedge clock);
    @(posedge clock);
    @(negedge clock);
    req_valid_i = 1'b0;
  endtask

  task automatic take_completion();
    while (!resp_valid_o) @(negedge clock);
    if (exp_op_q.size() == 0) begin
      errors++;
      $display("a completion arrived with no request outstanding");
    end else begin
      check_op("resp_op_o", resp_op_o, exp_op_q.pop_front());
      check_status("resp_status_o", resp_status_o, exp_status_q.pop_front());
      check_line("resp_rdata_o", resp_rdata_o, exp_line_q.pop_front());
    end
    resp_ready_i = 1'b1;
    @(posedge clock);
    @(negedge clock);
    resp_ready_i = 1'b0;
  endtask

  task automatic drain_completions();
    while (exp_op_q.size() > 0) take_completion();
  endtask

  task automatic test_reset_state();
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_bit("axi_aw_valid_o", axi_aw_valid_o, 1'b0);
    check_bit("axi_w_valid_o", axi_w_valid_o, 1'b0);
    check_bit("axi_b_ready_o", axi_b_ready_o, 1'b0);
    check_bit("axi_ar_valid_o", axi_ar_valid_o, 1'b0);
    check_bit("axi_r_ready_o", axi_r_ready_o, 1'b0);
  endtask

  task automatic test_full_line();
    logic [LINE_W-1:0] line;
    random_line(line);
    send_request(OP_WRITE, 32'h40, SIZE_D, 3'd7, line);
    take_completion();
    send_request(OP_READ, 32'h40, SIZE_D, 3'd7, '0);
    exp_line_q[exp_line_q.size() - 1] = line;  // The read must return the written line.
    take_completion();
  endtask

  task automatic test_narrow_writes();
    logic [LINE_W-1:0] line;
    random_line(line);
    send_request(OP_WRITE, 32'h105, SIZE_B, 3'd0, line);
    random_line(line);
    send_request(OP_WRITE, 32'h10b, SIZE_H, 3'd0, line);
    random_line(line);
    send_request(OP_WRITE, 32'h11c, SIZE_W, 3'd1, line);  // Crosses into the next beat.
    drain_completions();
    send_request(OP_READ, 32'h100, SIZE_D, 3'd7, '0);
    drain_completions();
  endtask

  task automatic test_backpressure();
    logic [LINE_W-1:0] line;
    int                sent;
    sent = 0;
    while (req_ready_o && sent < 8) begin
      random_line(line);
      send_request(OP_WRITE, 32'h200 + 32'(sent) * 32'h40, SIZE_D, 3'd7, line);
      sent++;
    end
    check_count("requests accepted before req_ready_o dropped", sent, 5);
    check_bit("req_ready_o", req_ready_o, 1'b0);
    drain_completions();
    send_request(OP_READ, 32'h200, SIZE_D, 3'd3, '0);  // Upper half of the line stays zero.
    for (int n = 1; n < 5; n++) begin
      send_request(OP_READ, 32'h200 + 32'(n) * 32'h40, SIZE_D, 3'd7, '0);
    end
    drain_completions();
  endtask

  task automatic test_error_range();
    logic [LINE_W-1:0] line;
    random_line(line);
    send_request(OP_WRITE, 32'h800, SIZE_D, 3'd7, line);
    send_request(OP_READ, 32'h800, SIZE_D, 3'd7, '0);
    drain_completions();
  endtask

  initial begin
    reset        = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = OP_READ;
    req_addr_i   = '0;
    req_size_i   = SIZE_D;
    req_blks_i   = '0;
    req_wdata_i  = '0;
    resp_ready_i = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = fill_byte(12'(i));
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset_state();
    test_full_line();
    test_narrow_writes();
    test_backpressure();
    test_error_range();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
axi_line_pkg.sv
line_req_queue.sv
axi_burst_engine.sv
axi_line_master.sv
tb_axi_slave.sv
tb_axi_line_master.sv

// ==== Makefile ====
TOP := tb_axi_line_master

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder"
	@echo "  help   show this list"

test:
	verilator --binary -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
